/* rtl/llm_int_consts.svh */
`ifndef LLM_INT_CONSTS_SVH
`define LLM_INT_CONSTS_SVH

// vector length, weight matrix is square.
`define LLM_VEC_LEN 4

// full and reduced precision in bits.
`define LLM_WIDTH 16
`define LLM_QWIDTH 8

// quantizing shift, full minus reduced precision.
`define LLM_QSHIFT 8

// outlier magnitude limit and most outliers per vector.
`define LLM_THRESHOLD 1024
`define LLM_HIGH_SLOTS 2

// weight address width, row times vector length plus column.
`define LLM_WADDR_W 4

`endif

/* rtl/llm_int_pkg.sv */
`include "llm_int_consts.svh"

package llm_int_pkg;

    // full precision and quantized values.
    typedef logic signed [`LLM_WIDTH-1:0] word_t;
    typedef logic signed [`LLM_QWIDTH-1:0] qword_t;

    // weight address, row-major.
    typedef logic [`LLM_WADDR_W-1:0] waddr_t;

    // two full words of product plus two growth bits.
    typedef logic signed [2*`LLM_WIDTH+1:0] acc_t;

    typedef word_t [`LLM_VEC_LEN-1:0] vec_t;
    typedef acc_t [`LLM_VEC_LEN-1:0] acc_vec_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_RUN,
        LANE_DRAIN
    } lane_state_t;

    typedef enum logic [1:0] {
        GATHER_IDLE,
        GATHER_BUSY,
        GATHER_HOLD
    } gather_state_t;

endpackage

/* rtl/weight_bus_if.sv */
`timescale 1ns/1ns

// read path from one compute lane to the weight arbiter.
interface weight_bus_if;
    import llm_int_pkg::*;

    // request held by the lane until granted.
    logic   req;
    waddr_t addr;

    // grant in the request cycle, data one cycle later.
    logic   gnt;
    word_t  rdata;

    modport lane (
        output req,
        output addr,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output rdata
    );

endinterface

/* rtl/outlier_scatter.sv */
`timescale 1ns/1ns
`include "llm_int_consts.svh"

module outlier_scatter (
    input  llm_int_pkg::vec_t data_in,
    output llm_int_pkg::vec_t high_vec,
    output llm_int_pkg::vec_t low_vec
);
    import llm_int_pkg::*;

    localparam int SLOT_W = $clog2(`LLM_HIGH_SLOTS + 1);

    // priority scan from index 0, first outliers win a slot.
    always_comb begin
        logic [SLOT_W-1:0]         taken;
        word_t                     elem;
        logic signed [`LLM_WIDTH:0] ext;
        logic signed [`LLM_WIDTH:0] mag;

        taken    = '0;
        high_vec = '0;
        low_vec  = '0;
        for (int i = 0; i < `LLM_VEC_LEN; i++) begin
            elem = data_in[i];
            // one extra bit so the most negative word has a magnitude.
            ext = elem;
            mag = (ext < 0) ? -ext : ext;
            if (mag > `LLM_THRESHOLD && taken < `LLM_HIGH_SLOTS) begin
                high_vec[i] = elem;
                taken       = taken + 1'b1;
            end else begin
                // low lane value, already in 8-bit range.
                low_vec[i] = elem >>> `LLM_QSHIFT;
            end
        end
    end

endmodule

/* rtl/weight_store.sv */
`timescale 1ns/1ns
`include "llm_int_consts.svh"

module weight_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                weight_wr,
    input  llm_int_pkg::waddr_t weight_addr,
    input  llm_int_pkg::word_t  weight_data,
    input  logic                rd_en,
    input  llm_int_pkg::waddr_t rd_addr,
    output llm_int_pkg::word_t  rd_full,
    output llm_int_pkg::qword_t rd_quant
);
    import llm_int_pkg::*;

    localparam int DEPTH = `LLM_VEC_LEN * `LLM_VEC_LEN;

    word_t  full_mem  [DEPTH];
    qword_t quant_mem [DEPTH];
    word_t  wr_shifted;

    // quantized copy of the incoming word.
    assign wr_shifted = weight_data >>> `LLM_QSHIFT;

    // both copies written on the same edge.
    always_ff @(posedge clk) begin
        if (weight_wr) begin
            full_mem[weight_addr]  <= weight_data;
            quant_mem[weight_addr] <= wr_shifted[`LLM_QWIDTH-1:0];
        end
    end

    // registered read, data valid one cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_full  <= full_mem[rd_addr];
            rd_quant <= quant_mem[rd_addr];
        end
    end

    a_rd_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> !$isunknown(rd_addr)
    ) else $error("weight read with unknown address");

endmodule

/* rtl/weight_arbiter.sv */
`timescale 1ns/1ns

module weight_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    weight_bus_if.arbiter       lanes [2],
    output logic                rd_en,
    output llm_int_pkg::waddr_t rd_addr,
    input  llm_int_pkg::word_t  rd_full,
    input  llm_int_pkg::qword_t rd_quant
);
    import llm_int_pkg::*;

    logic [1:0] req;
    logic [1:0] gnt;
    logic       prio;
    logic       owner;
    word_t      quant_ext;

    assign req[0] = lanes[0].req;
    assign req[1] = lanes[1].req;

    // prio names the lane that wins a tie.
    always_comb begin
        gnt = 2'b00;
        if (&req) begin
            gnt[prio] = 1'b1;
        end else begin
            gnt = req;
        end
    end

    assign rd_en   = |gnt;
    assign rd_addr = gnt[1] ? lanes[1].addr : lanes[0].addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio  <= 1'b0;
            owner <= 1'b0;
        end else begin
            if (&req) begin
                prio <= ~prio;
            end
            if (rd_en) begin
                owner <= gnt[1];
            end
        end
    end

    // lane 1 is the low lane and gets the quantized copy.
    assign quant_ext = rd_quant;

    assign lanes[0].gnt   = gnt[0];
    assign lanes[1].gnt   = gnt[1];
    assign lanes[0].rdata = owner ? '0 : rd_full;
    assign lanes[1].rdata = owner ? quant_ext : '0;

    // back-to-back ties hand the read port to the other lane.
    a_tie_turns: assert property (
        @(posedge clk) disable iff (!rst_n)
        &req && $past(&req) |-> $onehot(gnt) && gnt != $past(gnt)
    ) else $error("tied requests not granted to one lane in turn");

endmodule

/* rtl/mac_lane.sv */
`timescale 1ns/1ns
`include "llm_int_consts.svh"

module mac_lane #(
    parameter bit LANE_QUANT = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  llm_int_pkg::vec_t     vec_in,
    weight_bus_if.lane            bus,
    output llm_int_pkg::acc_vec_t acc_out,
    output logic                  done
);
    import llm_int_pkg::*;

    localparam int     IDX_W     = $clog2(`LLM_VEC_LEN);
    localparam waddr_t LAST_ADDR = waddr_t'(`LLM_VEC_LEN * `LLM_VEC_LEN - 1);

    lane_state_t                    state;
    waddr_t                         addr_q;
    waddr_t                         pend_addr;
    logic                           pend_valid;
    vec_t                           vec_q;
    acc_t                           acc_q [`LLM_VEC_LEN];
    logic [IDX_W-1:0]               row;
    logic [IDX_W-1:0]               col;
    word_t                          w_full;
    word_t                          x_full;
    qword_t                         w_q;
    qword_t                         x_q;
    logic signed [2*`LLM_WIDTH-1:0] prod;

    assign bus.req  = (state == LANE_RUN);
    assign bus.addr = addr_q;

    // row-major address of the weight in flight.
    assign row = pend_addr[2*IDX_W-1:IDX_W];
    assign col = pend_addr[IDX_W-1:0];

    assign w_full = bus.rdata;
    assign x_full = vec_q[col];
    assign w_q    = w_full[`LLM_QWIDTH-1:0];
    assign x_q    = x_full[`LLM_QWIDTH-1:0];

    // the low lane multiplies 8-bit operands only.
    always_comb begin
        if (LANE_QUANT) begin
            prod = w_q * x_q;
        end else begin
            prod = w_full * x_full;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= LANE_IDLE;
            addr_q     <= '0;
            pend_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            done       <= 1'b0;
            pend_valid <= bus.gnt;
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        addr_q <= '0;
                        state  <= LANE_RUN;
                    end
                end
                LANE_RUN: begin
                    if (bus.gnt) begin
                        if (addr_q == LAST_ADDR) begin
                            state <= LANE_DRAIN;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                LANE_DRAIN: begin
                    // last weight arrives, finish with a one-cycle strobe.
                    if (pend_valid) begin
                        done  <= 1'b1;
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // operand latch and per-row accumulation.
    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && start) begin
            vec_q <= vec_in;
            for (int r = 0; r < `LLM_VEC_LEN; r++) begin
                acc_q[r] <= '0;
            end
        end else if (pend_valid) begin
            acc_q[row] <= acc_q[row] + prod;
        end
        if (bus.gnt) begin
            pend_addr <= addr_q;
        end
    end

    for (genvar r = 0; r < `LLM_VEC_LEN; r++) begin : g_acc_out
        assign acc_out[r] = acc_q[r];
    end

    a_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr)
    ) else $error("lane request changed before grant");

endmodule

/* rtl/result_gather.sv */
`timescale 1ns/1ns
`include "llm_int_consts.svh"

module result_gather (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  data_in_valid,
    output logic                  data_in_ready,
    input  llm_int_pkg::acc_vec_t acc_high,
    input  llm_int_pkg::acc_vec_t acc_low,
    input  logic                  done_high,
    input  logic                  done_low,
    output logic                  start,
    output llm_int_pkg::vec_t     data_out,
    output logic                  data_out_valid,
    input  logic                  data_out_ready
);
    import llm_int_pkg::*;

    // accumulator width plus room for the low lane rescale.
    localparam int SUM_W = 2 * `LLM_WIDTH + 2 + 2 * `LLM_QSHIFT;

    gather_state_t state;
    logic          seen_high;
    logic          seen_low;
    logic          both_seen;
    vec_t          sum_vec;

    assign data_in_ready = (state == GATHER_IDLE);
    assign both_seen     = seen_high && seen_low;

    // rescale the low partial sum, add, keep the top word.
    always_comb begin
        acc_t                    h;
        acc_t                    l;
        logic signed [SUM_W-1:0] total;
        logic signed [SUM_W-1:0] scaled;

        for (int r = 0; r < `LLM_VEC_LEN; r++) begin
            h          = acc_high[r];
            l          = acc_low[r];
            total      = h + (l <<< (2 * `LLM_QSHIFT));
            scaled     = total >>> `LLM_WIDTH;
            sum_vec[r] = scaled[`LLM_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= GATHER_IDLE;
            start          <= 1'b0;
            seen_high      <= 1'b0;
            seen_low       <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                GATHER_IDLE: begin
                    if (data_in_valid && data_in_ready) begin
                        start     <= 1'b1;
                        seen_high <= 1'b0;
                        seen_low  <= 1'b0;
                        state     <= GATHER_BUSY;
                    end
                end
                GATHER_BUSY: begin
                    if (done_high) begin
                        seen_high <= 1'b1;
                    end
                    if (done_low) begin
                        seen_low <= 1'b1;
                    end
                    if (both_seen) begin
                        data_out_valid <= 1'b1;
                        state          <= GATHER_HOLD;
                    end
                end
                GATHER_HOLD: begin
                    // intake stays closed until the result is taken.
                    if (data_out_ready) begin
                        data_out_valid <= 1'b0;
                        state          <= GATHER_IDLE;
                    end
                end
                default: state <= GATHER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == GATHER_BUSY && both_seen) begin
            data_out <= sum_vec;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out)
    ) else $error("output changed under back-pressure");

endmodule

/* rtl/llm_int_linear.sv */
`timescale 1ns/1ns

module llm_int_linear (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                weight_wr,
    input  llm_int_pkg::waddr_t weight_addr,
    input  llm_int_pkg::word_t  weight_data,
    input  logic                data_in_valid,
    output logic                data_in_ready,
    input  llm_int_pkg::vec_t   data_in,
    output logic                data_out_valid,
    input  logic                data_out_ready,
    output llm_int_pkg::vec_t   data_out
);
    import llm_int_pkg::*;

    vec_t     data_q;
    vec_t     high_vec;
    vec_t     low_vec;
    logic     rd_en;
    waddr_t   rd_addr;
    word_t    rd_full;
    qword_t   rd_quant;
    acc_vec_t acc_high;
    acc_vec_t acc_low;
    logic     done_high;
    logic     done_low;
    logic     start;

    // lane 0 is the high lane, lane 1 the low lane.
    weight_bus_if wbus [2] ();

    // input vector captured on accept, lanes read it at start.
    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            data_q <= data_in;
        end
    end

    outlier_scatter u_scatter (
        .data_in  (data_q),
        .high_vec (high_vec),
        .low_vec  (low_vec)
    );

    weight_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_wr   (weight_wr),
        .weight_addr (weight_addr),
        .weight_data (weight_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_full     (rd_full),
        .rd_quant    (rd_quant)
    );

    weight_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .lanes    (wbus),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_full  (rd_full),
        .rd_quant (rd_quant)
    );

    mac_lane #(.LANE_QUANT(1'b0)) u_lane_high (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .vec_in  (high_vec),
        .bus     (wbus[0]),
        .acc_out (acc_high),
        .done    (done_high)
    );

    mac_lane #(.LANE_QUANT(1'b1)) u_lane_low (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .vec_in  (low_vec),
        .bus     (wbus[1]),
        .acc_out (acc_low),
        .done    (done_low)
    );

    result_gather u_gather (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .acc_high       (acc_high),
        .acc_low        (acc_low),
        .done_high      (done_high),
        .done_low       (done_low),
        .start          (start),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

/* test/tb_llm_int_model.svh */
`ifndef TB_LLM_INT_MODEL_SVH
`define TB_LLM_INT_MODEL_SVH

// 8-bit copy of a full word, arithmetic shift right.
function automatic qword_t quantize_word(input word_t w);
    int v;
    v = w;
    v = v >>> `LLM_QSHIFT;
    return qword_t'(v);
endfunction

// first outliers by index keep full precision, the rest are quantized.
function automatic void split_outliers(input vec_t v, output vec_t hi, output vec_t lo);
    int    slots;
    int    mag;
    int    q;
    word_t e;
    hi    = '0;
    lo    = '0;
    slots = 0;
    for (int i = 0; i < `LLM_VEC_LEN; i++) begin
        e   = v[i];
        mag = e;
        if (mag < 0) begin
            mag = -mag;
        end
        if (mag > `LLM_THRESHOLD && slots < `LLM_HIGH_SLOTS) begin
            hi[i] = e;
            slots++;
        end else begin
            q     = quantize_word(e);
            lo[i] = word_t'(q);
        end
    end
endfunction

// mixed dot product for every row, top word of the rescaled sum.
function automatic vec_t expected_output(input vec_t v,
                                         input word_t wts [`LLM_VEC_LEN*`LLM_VEC_LEN]);
    vec_t   hi;
    vec_t   lo;
    vec_t   res;
    word_t  w;
    word_t  xh;
    word_t  xl;
    longint acc_h;
    longint acc_l;
    longint total;
    split_outliers(v, hi, lo);
    for (int r = 0; r < `LLM_VEC_LEN; r++) begin
        acc_h = 0;
        acc_l = 0;
        for (int c = 0; c < `LLM_VEC_LEN; c++) begin
            w     = wts[r * `LLM_VEC_LEN + c];
            xh    = hi[c];
            xl    = lo[c];
            acc_h = acc_h + longint'(w) * longint'(xh);
            acc_l = acc_l + longint'(quantize_word(w)) * longint'(xl);
        end
        // both operands of the low lane lost QSHIFT bits.
        total  = acc_h + acc_l * (longint'(1) << (2 * `LLM_QSHIFT));
        res[r] = word_t'(total >>> `LLM_WIDTH);
    end
    return res;
endfunction

`endif

/* test/tb_llm_int_linear.sv */
`timescale 1ns/1ns
`include "llm_int_consts.svh"

module tb_llm_int_linear;
    import llm_int_pkg::*;

    `include "tb_llm_int_model.svh"

    localparam int     TABLE_LEN   = 12;
    localparam int     NUM_SETS    = 3;
    localparam int     DEPTH       = `LLM_VEC_LEN * `LLM_VEC_LEN;
    localparam longint WATCHDOG_NS = longint'(TABLE_LEN) * 200 * 8;

    logic   clk;
    logic   rst_n;
    logic   weight_wr;
    waddr_t weight_addr;
    word_t  weight_data;
    logic   data_in_valid;
    logic   data_in_ready;
    vec_t   data_in;
    logic   data_out_valid;
    logic   data_out_ready;
    vec_t   data_out;

    integer seed;
    int     word_errors;
    int     flag_errors;
    int     checks;
    int     loaded_set;

    // stimulus table: weight set, input vector, back-pressure cycles.
    int     tab_sel   [TABLE_LEN];
    vec_t   tab_vec   [TABLE_LEN];
    int     tab_delay [TABLE_LEN];
    word_t  wsets     [NUM_SETS][DEPTH];
    word_t  cur_w     [DEPTH];

    llm_int_linear UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .weight_wr      (weight_wr),
        .weight_addr    (weight_addr),
        .weight_data    (weight_data),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .data_in        (data_in),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .data_out       (data_out)
    );

    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            word_errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            flag_errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic vec_t make_vec(input int a, input int b, input int c, input int d);
        vec_t v;
        v[0] = word_t'(a);
        v[1] = word_t'(b);
        v[2] = word_t'(c);
        v[3] = word_t'(d);
        return v;
    endfunction

    task automatic build_weight_sets();
        int raw;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int a = 0; a < DEPTH; a++) begin
                raw = $random(seed);
                // last set uses smaller weights.
                wsets[s][a] = (s == 2) ? (word_t'(raw) >>> 3) : word_t'(raw);
            end
        end
    endtask

    task automatic build_table();
        int   e;
        vec_t v;
        // low path only, with threshold boundaries.
        tab_vec[0] = make_vec(100, -200, 300, -1000);
        tab_vec[1] = make_vec(1024, -1024, -1, 255);
        // one, two, three and four large elements.
        tab_vec[2] = make_vec(5000, 10, -20, 30);
        tab_vec[3] = make_vec(-3000, 200, 16000, -5);
        tab_vec[4] = make_vec(2000, -2000, 3000, 100);
        tab_vec[5] = make_vec(-32768, 32767, 1025, -1025);
        tab_sel[0] = 0;
        tab_sel[1] = 0;
        tab_sel[2] = 0;
        tab_sel[3] = 1;
        tab_sel[4] = 1;
        tab_sel[5] = 2;
        for (int i = 0; i < 6; i++) begin
            tab_delay[i] = (i * 3) % 5;
        end
        for (int i = 6; i < TABLE_LEN; i++) begin
            for (int k = 0; k < `LLM_VEC_LEN; k++) begin
                e = $random(seed);
                // random shift mixes outliers and small values.
                v[k] = word_t'(e) >>> (e[31:30] * 3);
            end
            tab_vec[i]   = v;
            tab_sel[i]   = i % NUM_SETS;
            tab_delay[i] = i % 4;
        end
    endtask

    task automatic load_weights(input int sel);
        for (int a = 0; a < DEPTH; a++) begin
            @(posedge clk);
            weight_wr   <= 1'b1;
            weight_addr <= waddr_t'(a);
            weight_data <= wsets[sel][a];
            cur_w[a] = wsets[sel][a];
        end
        @(posedge clk);
        weight_wr  <= 1'b0;
        loaded_set = sel;
    endtask

    task automatic run_entry(input int idx);
        vec_t exp;
        vec_t first;
        if (tab_sel[idx] != loaded_set) begin
            load_weights(tab_sel[idx]);
        end
        exp = expected_output(tab_vec[idx], cur_w);
        @(posedge clk);
        data_in       <= tab_vec[idx];
        data_in_valid <= 1'b1;
        @(posedge clk);
        while (!data_in_ready) @(posedge clk);
        data_in_valid <= 1'b0;
        while (!data_out_valid) @(posedge clk);
        first = data_out;
        for (int r = 0; r < `LLM_VEC_LEN; r++) begin
            check_word($sformatf("entry %0d data_out[%0d]", idx, r), data_out[r], exp[r]);
        end
        // output held while the consumer stalls.
        for (int d = 0; d < tab_delay[idx]; d++) begin
            @(posedge clk);
            check_flag("data_out_valid", data_out_valid, 1'b1);
            check_flag("data_in_ready", data_in_ready, 1'b0);
            for (int r = 0; r < `LLM_VEC_LEN; r++) begin
                check_word($sformatf("held data_out[%0d]", r), data_out[r], first[r]);
            end
        end
        data_out_ready <= 1'b1;
        @(posedge clk);
        data_out_ready <= 1'b0;
        @(posedge clk);
        check_flag("data_out_valid", data_out_valid, 1'b0);
        check_flag("data_in_ready", data_in_ready, 1'b1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout, the DUT did not finish the table within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        weight_wr      = 1'b0;
        weight_addr    = '0;
        weight_data    = '0;
        data_in_valid  = 1'b0;
        data_in        = '0;
        data_out_ready = 1'b0;
        seed           = 32'h9544355c;
        word_errors    = 0;
        flag_errors    = 0;
        checks         = 0;
        loaded_set     = -1;
        build_weight_sets();
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("data_out_valid", data_out_valid, 1'b0);
        check_flag("data_in_ready", data_in_ready, 1'b1);
        for (int i = 0; i < TABLE_LEN; i++) begin
            run_entry(i);
        end
        $display("checks %0d, word mismatches %0d, handshake mismatches %0d",
                 checks, word_errors, flag_errors);
        if (word_errors + flag_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* llm_int_linear.f */
+incdir+rtl
+incdir+test
rtl/llm_int_pkg.sv
rtl/weight_bus_if.sv
rtl/outlier_scatter.sv
rtl/weight_store.sv
rtl/weight_arbiter.sv
rtl/mac_lane.sv
rtl/result_gather.sv
rtl/llm_int_linear.sv
test/tb_llm_int_linear.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_llm_int_linear
FILELIST  ?= llm_int_linear.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh test/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
